// ==== data_mem_pkg.sv ====
`default_nettype none

package data_mem_pkg;

  //////////////////////////////////////////////////
  // Memory geometry.
  //////////////////////////////////////////////////

  localparam int MEM_DEPTH = 256;               // 32-bit words in the RAM.
  localparam int WORD_W    = 32;                // Data width.
  localparam int BE_W      = WORD_W / 8;        // One enable per byte lane.
  localparam int WADDR_W   = $clog2(MEM_DEPTH); // Word address.
  localparam int BADDR_W   = WADDR_W + 2;       // Byte address seen by the core.

  // A clear sweep zeroes one word per cycle.
  localparam int SWEEP_CYCLES = MEM_DEPTH;

  //////////////////////////////////////////////////
  // Vector types.
  //////////////////////////////////////////////////

  typedef logic [WORD_W-1:0]  word_t;     // Data word.
  typedef logic [WADDR_W-1:0] waddr_t;    // Word address.
  typedef logic [BADDR_W-1:0] baddr_t;    // Byte address.
  typedef logic [BE_W-1:0]    be_t;       // Byte-lane enables.
  typedef logic [1:0]         mem_size_t; // Access size code.

  // Access size codes as the MIPS core sends them.
  localparam mem_size_t SIZE_BYTE = 2'd0; // lb / sb.
  localparam mem_size_t SIZE_HALF = 2'd1; // lh / sh.
  localparam mem_size_t SIZE_WORD = 2'd2; // lw / sw.

endpackage

`default_nettype wire

// ==== mem_req_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_req_stage (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  logic                    i_block,      // Sweep or dump owns the RAM.
  input  logic                    i_mem_en,
  input  logic                    i_mem_we,
  input  data_mem_pkg::mem_size_t i_mem_size,
  input  data_mem_pkg::baddr_t    i_mem_addr,
  input  data_mem_pkg::word_t     i_mem_wdata,
  output logic                    o_req_valid,
  output logic                    o_req_we,
  output data_mem_pkg::be_t       o_req_be,
  output data_mem_pkg::waddr_t    o_req_waddr,
  output data_mem_pkg::word_t     o_req_wdata,
  output logic                    o_misaligned
);

  logic                accept;    // Request taken this cycle.
  logic                mis;       // Address does not fit the size.
  data_mem_pkg::be_t   be_dec;    // Lane enables before registering.
  data_mem_pkg::word_t wdata_rep; // Store data copied to every lane.

  assign accept = i_mem_en & ~i_block;

  //////////////////////////////////////////////////
  // Size and alignment decode.
  //////////////////////////////////////////////////

  always_comb begin
    mis       = 1'b0;
    be_dec    = '0;
    wdata_rep = i_mem_wdata;
    case (i_mem_size)
      data_mem_pkg::SIZE_BYTE: begin
        be_dec    = data_mem_pkg::be_t'(1) << i_mem_addr[1:0]; // One lane.
        wdata_rep = {4{i_mem_wdata[7:0]}};
      end
      data_mem_pkg::SIZE_HALF: begin
        mis       = i_mem_addr[0];                         // Odd halfword.
        be_dec    = i_mem_addr[1] ? 4'b1100 : 4'b0011;     // Upper or lower half.
        wdata_rep = {2{i_mem_wdata[15:0]}};
      end
      data_mem_pkg::SIZE_WORD: begin
        mis    = |i_mem_addr[1:0];                          // Not on a word boundary.
        be_dec = 4'b1111;
      end
      default: be_dec = '0; // Reserved code, nothing written.
    endcase
    if (mis) begin
      be_dec = '0;                                          // Misaligned store is dropped.
    end
  end

  //////////////////////////////////////////////////
  // Request register.
  //////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_req_valid  <= 1'b0;
      o_misaligned <= 1'b0;
    end else begin
      o_req_valid  <= accept;
      o_misaligned <= accept & mis; // One cycle after acceptance.
    end
  end

  // Payload follows the valid bit.
  always_ff @(posedge i_clk) begin
    o_req_we    <= i_mem_we;
    o_req_be    <= be_dec;
    o_req_waddr <= i_mem_addr[data_mem_pkg::BADDR_W-1:2]; // Word part of the address.
    o_req_wdata <= wdata_rep;
  end

endmodule

`default_nettype wire

// ==== data_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module data_ram (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic                 i_soft_rst,   // Pulse from the control side.
  input  logic                 i_rd,
  input  logic                 i_we,
  input  data_mem_pkg::be_t    i_be,
  input  data_mem_pkg::waddr_t i_waddr,      // Shared read and write address.
  input  data_mem_pkg::word_t  i_wdata,
  output data_mem_pkg::word_t  o_rdata,
  output logic                 o_rvalid,
  output logic                 o_clear_busy,
  output logic                 o_wr,         // Write committed this cycle.
  output data_mem_pkg::waddr_t o_wr_addr
);

  typedef enum logic {
    RAM_IDLE,
    RAM_SWEEP
  } sweep_st_t;

  sweep_st_t            sweep_st;
  data_mem_pkg::waddr_t sweep_cnt;          // Word being zeroed.
  logic                 sweeping;
  logic                 sweep_last;

  data_mem_pkg::word_t  mem [data_mem_pkg::MEM_DEPTH];

  // Port signals after the sweep override.
  data_mem_pkg::waddr_t wr_addr;
  data_mem_pkg::be_t    wr_be;
  data_mem_pkg::word_t  wr_data;

  assign sweeping     = (sweep_st == RAM_SWEEP);
  assign sweep_last   = (sweep_cnt == data_mem_pkg::waddr_t'(data_mem_pkg::SWEEP_CYCLES - 1));
  assign o_clear_busy = sweeping;

  //////////////////////////////////////////////////
  // Clear sweep.
  //////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_rst || i_soft_rst) begin
      sweep_st  <= RAM_SWEEP;             // Busy from the next cycle on.
      sweep_cnt <= '0;
    end else if (sweeping) begin
      sweep_cnt <= sweep_cnt + 1'b1;
      if (sweep_last) begin
        sweep_st <= RAM_IDLE;
      end
    end
  end

  // The sweep takes the write port and writes zeros.
  assign wr_addr = sweeping ? sweep_cnt : i_waddr;
  assign wr_be   = sweeping ? '1 : (i_we ? i_be : '0);
  assign wr_data = sweeping ? '0 : i_wdata;

  // Committed core writes, for the dirty bits.
  assign o_wr      = ~sweeping & i_we & (|i_be);
  assign o_wr_addr = i_waddr;

  //////////////////////////////////////////////////
  // Storage.
  //////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    for (int b = 0; b < data_mem_pkg::BE_W; b++) begin
      if (wr_be[b]) begin
        mem[wr_addr][8*b +: 8] <= wr_data[8*b +: 8]; // Byte lane b.
      end
    end
    if (i_rd && !sweeping) begin
      o_rdata <= mem[i_waddr];                       // Old word on a same-cycle write.
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_rvalid <= 1'b0;
    end else begin
      o_rvalid <= i_rd & ~sweeping;  // Reads during a sweep are lost.
    end
  end

endmodule

`default_nettype wire

// ==== dirty_bit_tracker.sv ====
`timescale 1ns/100ps
`default_nettype none

module dirty_bit_tracker (
  input  logic                 i_clk,
  input  logic                 i_clear,      // High for the whole sweep.
  input  logic                 i_set,        // Write reached the RAM.
  input  data_mem_pkg::waddr_t i_set_addr,
  input  data_mem_pkg::waddr_t i_scan_addr,  // Dump engine probe.
  output logic                 o_scan_dirty
);

  //////////////////////////////////////////////////
  // Dirty array.
  //////////////////////////////////////////////////

  // One bit per RAM word.
  logic [data_mem_pkg::MEM_DEPTH-1:0] dirty;

  // Clear wins over a set in the same cycle.
  always_ff @(posedge i_clk) begin
    if (i_clear) begin
      dirty <= '0;                       // Whole array at once.
    end else if (i_set) begin
      dirty[i_set_addr] <= 1'b1;         // Sticky until the next sweep.
    end
  end

  // Combinational probe for the dump scan.
  assign o_scan_dirty = dirty[i_scan_addr];

endmodule

`default_nettype wire

// ==== dirty_dump_engine.sv ====
`timescale 1ns/100ps
`default_nettype none

module dirty_dump_engine (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic                 i_start,      // Pulse from the debug unit.
  input  logic                 i_clear_busy,
  input  logic                 i_scan_dirty,
  input  data_mem_pkg::word_t  i_rdata,
  output data_mem_pkg::waddr_t o_scan_addr,  // Probe and RAM read address.
  output logic                 o_rd,
  output logic                 o_busy,
  output logic                 o_valid,
  output data_mem_pkg::waddr_t o_addr,
  output data_mem_pkg::word_t  o_data,
  output logic                 o_done
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SCAN,
    ST_FINISH
  } dump_st_t;

  dump_st_t             state;
  data_mem_pkg::waddr_t scan_addr;   // Next word to probe.
  logic                 scan_last;
  logic                 rd_q;        // Read issued last cycle.
  data_mem_pkg::waddr_t addr_q;      // Its address.

  assign scan_last = (scan_addr == data_mem_pkg::waddr_t'(data_mem_pkg::MEM_DEPTH - 1));

  //////////////////////////////////////////////////
  // Scan FSM.
  //////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state     <= ST_IDLE;
      scan_addr <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (i_start && !i_clear_busy) begin // Start is ignored during a sweep.
            state     <= ST_SCAN;
            scan_addr <= '0;
          end
        end
        ST_SCAN: begin
          if (i_clear_busy) begin
            state <= ST_IDLE;                 // Memory is being wiped, abort.
          end else if (scan_last) begin
            state <= ST_FINISH;               // Last read still in flight.
          end else begin
            scan_addr <= scan_addr + 1'b1;
          end
        end
        ST_FINISH: state <= ST_IDLE;
        default:   state <= ST_IDLE;
      endcase
    end
  end

  // Read only the words marked dirty.
  assign o_rd        = (state == ST_SCAN) & i_scan_dirty & ~i_clear_busy;
  assign o_scan_addr = scan_addr;

  //////////////////////////////////////////////////
  // Output pipeline.
  //////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      rd_q <= 1'b0;
    end else begin
      rd_q <= o_rd;                  // Lines up with the RAM read latency.
    end
  end

  always_ff @(posedge i_clk) begin
    addr_q <= scan_addr;             // Address travels with its read.
  end

  assign o_valid = rd_q;
  assign o_addr  = addr_q;
  assign o_data  = i_rdata;          // Registered inside the RAM.
  assign o_busy  = (state != ST_IDLE);
  assign o_done  = (state == ST_FINISH); // Same cycle as the last valid, if any.

endmodule

`default_nettype wire

// ==== data_mem_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module data_mem_top (
  input  logic                    i_clk,
  input  logic                    i_rst,
  // Core side.
  input  logic                    i_mem_en,
  input  logic                    i_mem_we,
  input  data_mem_pkg::mem_size_t i_mem_size,
  input  data_mem_pkg::baddr_t    i_mem_addr,
  input  data_mem_pkg::word_t     i_mem_wdata,
  output data_mem_pkg::word_t     o_mem_rdata,
  output logic                    o_mem_rvalid,
  output logic                    o_misaligned,
  // Control side.
  input  logic                    i_soft_rst,
  output logic                    o_clear_busy,
  // Debug side.
  input  logic                    i_dump_start,
  output logic                    o_dump_busy,
  output logic                    o_dump_valid,
  output data_mem_pkg::waddr_t    o_dump_addr,
  output data_mem_pkg::word_t     o_dump_data,
  output logic                    o_dump_done
);

  // Request stage to the RAM port.
  logic                 req_valid;
  logic                 req_we;
  data_mem_pkg::be_t    req_be;
  data_mem_pkg::waddr_t req_waddr;
  data_mem_pkg::word_t  req_wdata;
  logic                 req_block;

  // RAM port after the mux.
  logic                 ram_rd;
  logic                 ram_we;
  data_mem_pkg::waddr_t ram_addr;
  data_mem_pkg::word_t  ram_rdata;
  logic                 ram_rvalid;
  logic                 ram_wr;
  data_mem_pkg::waddr_t ram_waddr;

  logic                 clear_busy;
  logic                 dump_busy;
  logic                 dump_rd;
  data_mem_pkg::waddr_t dump_addr;
  logic                 scan_dirty;

  //////////////////////////////////////////////////
  // RAM port mux.
  //////////////////////////////////////////////////

  assign req_block = clear_busy | dump_busy;  // Core is locked out.
  assign ram_rd    = dump_busy ? dump_rd : (req_valid & ~req_we);
  assign ram_we    = ~dump_busy & req_valid & req_we; // Dump never writes.
  assign ram_addr  = dump_busy ? dump_addr : req_waddr;

  assign o_mem_rdata  = ram_rdata;
  assign o_mem_rvalid = ram_rvalid & ~dump_busy; // Dump reads stay internal.
  assign o_clear_busy = clear_busy;
  assign o_dump_busy  = dump_busy;

  mem_req_stage mem_req_stage_i (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_block      (req_block),
    .i_mem_en     (i_mem_en),
    .i_mem_we     (i_mem_we),
    .i_mem_size   (i_mem_size),
    .i_mem_addr   (i_mem_addr),
    .i_mem_wdata  (i_mem_wdata),
    .o_req_valid  (req_valid),
    .o_req_we     (req_we),
    .o_req_be     (req_be),
    .o_req_waddr  (req_waddr),
    .o_req_wdata  (req_wdata),
    .o_misaligned (o_misaligned)
  );

  data_ram data_ram_i (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_soft_rst   (i_soft_rst),
    .i_rd         (ram_rd),
    .i_we         (ram_we),
    .i_be         (req_be),
    .i_waddr      (ram_addr),
    .i_wdata      (req_wdata),
    .o_rdata      (ram_rdata),
    .o_rvalid     (ram_rvalid),
    .o_clear_busy (clear_busy),
    .o_wr         (ram_wr),
    .o_wr_addr    (ram_waddr)
  );

  dirty_bit_tracker dirty_bit_tracker_i (
    .i_clk        (i_clk),
    .i_clear      (clear_busy),
    .i_set        (ram_wr),
    .i_set_addr   (ram_waddr),
    .i_scan_addr  (dump_addr),
    .o_scan_dirty (scan_dirty)
  );

  dirty_dump_engine dirty_dump_engine_i (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_start      (i_dump_start),
    .i_clear_busy (clear_busy),
    .i_scan_dirty (scan_dirty),
    .i_rdata      (ram_rdata),
    .o_scan_addr  (dump_addr),
    .o_rd         (dump_rd),
    .o_busy       (dump_busy),
    .o_valid      (o_dump_valid),
    .o_addr       (o_dump_addr),
    .o_data       (o_dump_data),
    .o_done       (o_dump_done)
  );

endmodule

`default_nettype wire

// ==== data_mem_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

module data_mem_assert (
  input logic i_clk,
  input logic i_rst,
  input logic i_dump_start,
  input logic i_mem_rvalid,
  input logic i_misaligned,
  input logic i_clear_busy,
  input logic i_dump_busy,
  input logic i_dump_valid,
  input logic i_dump_done
);

  int unsigned fail_cnt = 0; // Failed assertions so far.

  task automatic count_failure(input string msg);
    $error("%s", msg);
    fail_cnt++;
  endtask

  //////////////////////////////////////////////////
  // Reset and sweep.
  //////////////////////////////////////////////////

  assert property (@(posedge i_clk) i_rst |=> i_clear_busy && !i_dump_busy && !i_mem_rvalid
    && !i_misaligned && !i_dump_valid && !i_dump_done)
    else count_failure("outputs are not in their reset state after a reset cycle");

  // Core requests are dropped during a sweep.
  assert property (@(posedge i_clk) disable iff (i_rst) $past(i_clear_busy) |-> !i_misaligned)
    else count_failure("misaligned pulse from a request taken during a sweep");

  assert property (@(posedge i_clk) disable iff (i_rst) i_clear_busy |=> !i_dump_busy)
    else count_failure("dump engine is busy while the memory is being cleared");

  //////////////////////////////////////////////////
  // Dump protocol.
  //////////////////////////////////////////////////

  assert property (@(posedge i_clk) disable iff (i_rst)
    $rose(i_dump_busy) |-> $past(i_dump_start) && !$past(i_clear_busy))
    else count_failure("dump started without a start pulse");

  assert property (@(posedge i_clk) disable iff (i_rst) i_dump_valid |-> i_dump_busy)
    else count_failure("dump valid pulse outside a dump");

  assert property (@(posedge i_clk) disable iff (i_rst)
    i_dump_done |=> !i_dump_busy && !i_dump_done)
    else count_failure("dump done is not a single pulse that ends the dump");

  // A load offered while the dump owns the port never comes back.
  assert property (@(posedge i_clk) disable iff (i_rst) $past(i_dump_busy, 2) |-> !i_mem_rvalid)
    else count_failure("core load taken while a dump was running");

endmodule

bind data_mem_top data_mem_assert data_mem_assert_i (
  .i_clk        (i_clk),
  .i_rst        (i_rst),
  .i_dump_start (i_dump_start),
  .i_mem_rvalid (o_mem_rvalid),
  .i_misaligned (o_misaligned),
  .i_clear_busy (o_clear_busy),
  .i_dump_busy  (o_dump_busy),
  .i_dump_valid (o_dump_valid),
  .i_dump_done  (o_dump_done)
);

`default_nettype wire

// ==== tb_data_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_data_mem;

  localparam int CLK_PERIOD = 10;
  localparam int DEPTH      = data_mem_pkg::MEM_DEPTH;
  // Reset, two sweeps, three full dump scans and the request bursts.
  localparam int RUN_CYCLES = 10 + 2 * data_mem_pkg::SWEEP_CYCLES + 3 * (DEPTH + 8) + 250;

  logic                    i_clk;
  logic                    i_rst;
  logic                    i_mem_en;
  logic                    i_mem_we;
  data_mem_pkg::mem_size_t i_mem_size;
  data_mem_pkg::baddr_t    i_mem_addr;
  data_mem_pkg::word_t     i_mem_wdata;
  data_mem_pkg::word_t     o_mem_rdata;
  logic                    o_mem_rvalid;
  logic                    o_misaligned;
  logic                    i_soft_rst;
  logic                    o_clear_busy;
  logic                    i_dump_start;
  logic                    o_dump_busy;
  logic                    o_dump_valid;
  data_mem_pkg::waddr_t    o_dump_addr;
  data_mem_pkg::word_t     o_dump_data;
  logic                    o_dump_done;

  data_mem_pkg::word_t     model [DEPTH];     // Reference memory.
  logic                    dirty_ref [DEPTH]; // Reference dirty set.
  int                      load_due_q [$];    // Negedge at which each rvalid is due.
  data_mem_pkg::word_t     load_data_q [$];
  int                      mis_due_q [$];
  data_mem_pkg::waddr_t    dump_addr_q [$];   // Dirty words still to come out.
  data_mem_pkg::word_t     dump_data_q [$];
  int                      neg_cnt = 0;
  int                      err_cnt = 0;
  int                      seed = 80234;

  data_mem_top data_mem_top_i (.*);

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  initial begin
    #(2 * RUN_CYCLES * CLK_PERIOD);
    $display("Error at %0t: watchdog expired before the tests finished", $time);
    $display("RESULT: FAIL");
    $finish;
  end

  task automatic report_error(input string msg);
    $display("Error at %0t: %s", $time, msg);
    err_cnt++;
  endtask

  //////////////////////////////////////////////////
  // Output monitor sampled on the falling edge.
  //////////////////////////////////////////////////

  always @(negedge i_clk) begin
    logic exp_rv;
    logic exp_mis;
    neg_cnt++;
    exp_rv  = (load_due_q.size() > 0) && (load_due_q[0] == neg_cnt);
    exp_mis = (mis_due_q.size() > 0) && (mis_due_q[0] == neg_cnt);
    if (!i_rst) begin
      assert (o_mem_rvalid == exp_rv)
        else report_error($sformatf("o_mem_rvalid is %0b, expected %0b", o_mem_rvalid, exp_rv));
      if (exp_rv) begin
        assert (o_mem_rdata == load_data_q[0])
          else report_error($sformatf("load data %h, expected %h", o_mem_rdata, load_data_q[0]));
        void'(load_due_q.pop_front());
        void'(load_data_q.pop_front());
      end
      assert (o_misaligned == exp_mis)
        else report_error($sformatf("o_misaligned is %0b, expected %0b", o_misaligned, exp_mis));
      if (exp_mis) void'(mis_due_q.pop_front());
      if (o_dump_valid) begin
        assert (dump_addr_q.size() > 0) else report_error("dump valid with no dirty word left");
        if (dump_addr_q.size() > 0) begin
          assert (o_dump_addr == dump_addr_q[0] && o_dump_data == dump_data_q[0])
            else report_error($sformatf("dump word %h:%h, expected %h:%h", o_dump_addr,
                                        o_dump_data, dump_addr_q[0], dump_data_q[0]));
          void'(dump_addr_q.pop_front());
          void'(dump_data_q.pop_front());
        end
      end
      if (o_dump_done) begin
        assert (dump_addr_q.size() == 0)
          else report_error($sformatf("dump done with %0d words missing", dump_addr_q.size()));
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus tasks.
  //////////////////////////////////////////////////

  // One request per call. The reference model follows the byte-lane rules.
  task automatic issue(input logic we, input data_mem_pkg::mem_size_t size,
                       input data_mem_pkg::baddr_t addr, input data_mem_pkg::word_t wdata);
    data_mem_pkg::waddr_t w;
    logic                 mis;
    w   = addr[data_mem_pkg::BADDR_W-1:2];
    mis = (size == data_mem_pkg::SIZE_HALF && addr[0]) ||
          (size == data_mem_pkg::SIZE_WORD && addr[1:0] != 2'b00);
    @(posedge i_clk);
    i_mem_en    <= 1'b1;
    i_mem_we    <= we;
    i_mem_size  <= size;
    i_mem_addr  <= addr;
    i_mem_wdata <= wdata;
    if (mis) mis_due_q.push_back(neg_cnt + 2);       // Pulse one cycle after acceptance.
    if (!we) begin
      load_due_q.push_back(neg_cnt + 3);             // Two-cycle load latency.
      load_data_q.push_back(model[w]);
    end else if (!mis) begin
      case (size)
        data_mem_pkg::SIZE_BYTE: model[w][8*addr[1:0] +: 8] = wdata[7:0];
        data_mem_pkg::SIZE_HALF: model[w][16*addr[1] +: 16] = wdata[15:0];
        default:                 model[w] = wdata;
      endcase
      dirty_ref[w] = 1'b1;
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge i_clk);
      i_mem_en <= 1'b0;
    end
  endtask

  // Called right after the edge that starts a sweep.
  task automatic check_sweep();
    int n = 0;
    @(negedge i_clk);
    while (o_clear_busy && n <= data_mem_pkg::SWEEP_CYCLES) begin
      n++;
      @(negedge i_clk);
    end
    assert (n == data_mem_pkg::SWEEP_CYCLES)
      else report_error($sformatf("o_clear_busy high for %0d cycles", n));
  endtask

  task automatic soft_reset();
    @(posedge i_clk);
    i_soft_rst <= 1'b1;
    @(posedge i_clk);
    i_soft_rst   <= 1'b0;
    i_dump_start <= 1'b1;                            // Both land while the sweep runs.
    i_mem_en     <= 1'b1;
    i_mem_we     <= 1'b1;
    i_mem_size   <= data_mem_pkg::SIZE_WORD;
    i_mem_addr   <= {8'd3, 2'b10};                   // Misaligned word store.
    foreach (model[a]) begin
      model[a]     = '0;
      dirty_ref[a] = 1'b0;
    end
    fork
      check_sweep();
      begin
        @(posedge i_clk);
        i_dump_start <= 1'b0;
        i_mem_en     <= 1'b0;
      end
    join
  endtask

  task automatic run_dump();
    int n = 0;
    for (int a = 0; a < DEPTH; a++) begin
      if (dirty_ref[a]) begin
        dump_addr_q.push_back(data_mem_pkg::waddr_t'(a)); // Ascending order.
        dump_data_q.push_back(model[a]);
      end
    end
    @(posedge i_clk);
    i_dump_start <= 1'b1;
    @(posedge i_clk);
    i_dump_start <= 1'b0;
    i_mem_en     <= 1'b1;                            // Core load while the dump owns the port.
    i_mem_we     <= 1'b0;
    i_mem_size   <= data_mem_pkg::SIZE_WORD;
    i_mem_addr   <= '0;
    fork
      idle(1);
      begin
        @(negedge i_clk);
        while (!o_dump_done && n < DEPTH + 8) begin
          assert (o_dump_busy) else report_error("o_dump_busy dropped before o_dump_done");
          n++;
          @(negedge i_clk);
        end
      end
    join
    assert (o_dump_done) else report_error("dump did not finish in time");
    @(posedge i_clk);
  endtask

  //////////////////////////////////////////////////
  // Test sequence.
  //////////////////////////////////////////////////

  initial begin
    data_mem_pkg::waddr_t    w;
    logic [1:0]              off;
    data_mem_pkg::mem_size_t size;
    int unsigned             assert_cnt;
    i_rst        = 1'b1;
    i_mem_en     = 1'b0;
    i_mem_we     = 1'b0;
    i_mem_size   = data_mem_pkg::SIZE_WORD;
    i_mem_addr   = '0;
    i_mem_wdata  = '0;
    i_soft_rst   = 1'b0;
    i_dump_start = 1'b0;
    foreach (model[a]) begin
      model[a]     = '0;
      dirty_ref[a] = 1'b0;
    end
    repeat (10) @(posedge i_clk);
    i_rst <= 1'b0;
    check_sweep();
    run_dump();                                      // Nothing dirty yet.
    repeat (40) begin                                // Store, then load the same word.
      size = data_mem_pkg::mem_size_t'($unsigned($random(seed)) % 3);
      w    = data_mem_pkg::waddr_t'($random(seed) & 31);
      off  = 2'($random(seed));
      if (size == data_mem_pkg::SIZE_HALF) off[0] = 1'b0;
      else if (size == data_mem_pkg::SIZE_WORD) off = 2'b00;
      issue(1'b1, size, {w, off}, $random(seed));
      issue(1'b0, data_mem_pkg::SIZE_WORD, {w, 2'b00}, '0);
    end
    for (int a = 0; a < 32; a++) issue(1'b0, data_mem_pkg::SIZE_WORD, {8'(a), 2'b00}, '0);
    for (int a = 0; a < 8; a++) begin                // Misaligned stores write nothing.
      issue(1'b1, data_mem_pkg::SIZE_HALF, {8'(a), 2'b01}, $random(seed));
      issue(1'b1, data_mem_pkg::SIZE_WORD, {8'(a), 2'b10}, $random(seed));
      issue(1'b1, data_mem_pkg::SIZE_HALF, {8'(a), 2'b11}, $random(seed));
      issue(1'b0, data_mem_pkg::SIZE_WORD, {8'(a), 2'b00}, '0);
    end
    idle(4);
    run_dump();
    repeat (10) issue(1'b1, data_mem_pkg::SIZE_WORD, {8'($random(seed)), 2'b00}, $random(seed));
    idle(4);
    soft_reset();
    for (int a = 0; a < 32; a++) issue(1'b0, data_mem_pkg::SIZE_WORD, {8'(a), 2'b00}, '0);
    idle(4);
    run_dump();                                      // Only done after the sweep.
    idle(4);
    assert (load_due_q.size() == 0 && mis_due_q.size() == 0)
      else report_error("expected load or misaligned pulses never arrived");
    assert_cnt = data_mem_top_i.data_mem_assert_i.fail_cnt;
    $display("Error counts: %0d testbench checks, %0d bound assertions", err_cnt, assert_cnt);
    if (err_cnt == 0 && assert_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
data_mem_pkg.sv
mem_req_stage.sv
data_ram.sv
dirty_bit_tracker.sv
dirty_dump_engine.sv
data_mem_top.sv
data_mem_assert.sv
tb_data_mem.sv
